// ==== files.f ====
+incdir+rtl
rtl/uart_bus_pkg.sv
rtl/uart_line_pkg.sv
rtl/fifo_if.sv
rtl/fifo.sv
rtl/uart_regs.sv
rtl/uart_tx.sv
rtl/uart_rx.sv
rtl/uart_top.sv
bench/tb_uart.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module tb_uart -f files.f -o tb_uart_sim \
  && ./obj_dir/tb_uart_sim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or simulation step failed"; exit 1; }
cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation reported failures"; exit 1; }
echo "simulation passed"

// ==== bench/tb_uart.sv ====
`default_nettype none
`include "uart_params.svh"

module tb_uart;

  import uart_bus_pkg::*;

  localparam int ACK_LIMIT  = 20;    // clocks an access may wait for ack.
  localparam int POLL_LIMIT = 4000;  // status reads, three clocks each.
  localparam int IRQ_LIMIT  = 2000;

  localparam logic [7:0] ST_TX_EMPTY = 8'h01;
  localparam logic [7:0] ST_TX_FULL  = 8'h02;
  localparam logic [7:0] ST_RX_EMPTY = 8'h04;
  localparam logic [7:0] ST_TX_BUSY  = 8'h40;
  localparam logic [7:0] ST_OVERRUN  = 8'h80;

  logic                        clk;
  logic                        rst_n;
  logic                        wb_cyc;
  logic                        wb_stb;
  logic                        wb_we;
  logic [`UART_ADR_WIDTH-1:0]  wb_adr;
  logic [`UART_DATA_WIDTH-1:0] wb_wdat;
  logic [`UART_DATA_WIDTH-1:0] wb_rdat;
  logic                        wb_ack;
  logic                        txd;
  logic                        irq;

  integer     seed;
  int         errors;
  int         checks;
  logic [7:0] model_q [$];  // bytes the receiver must deliver, oldest first.
  logic [7:0] div_m;
  logic [7:0] ctrl_m;

  uart_top UUT (
    .clk      (clk),
    .rst_n    (rst_n),
    .wb_cyc_i (wb_cyc),
    .wb_stb_i (wb_stb),
    .wb_we_i  (wb_we),
    .wb_adr_i (wb_adr),
    .wb_dat_i (wb_wdat),
    .wb_dat_o (wb_rdat),
    .wb_ack_o (wb_ack),
    .txd_o    (txd),
    .rxd_i    (txd),  // serial loopback.
    .irq_o    (irq)
  );

  always #2 clk = ~clk;

  task automatic check_equal(string name, logic [7:0] got, logic [7:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] time %0t %s got %02h expected %02h", $time, name, got, exp);
    end
  endtask

  task automatic abort_on_timeout(string what);
    $display("timeout while waiting for %s at time %0t", what, $time);
    $display("checks: %0d errors: %0d", checks, errors);
    $display("ERRORS FOUND");
    $finish;
  endtask

  task automatic bus_cycle(logic we, reg_addr_e adr, logic [7:0] wdat,
                           output logic [7:0] rdat);
    int waited;
    waited = 0;
    @(posedge clk);
    wb_cyc  <= 1'b1;
    wb_stb  <= 1'b1;
    wb_we   <= we;
    wb_adr  <= adr;
    wb_wdat <= wdat;
    @(negedge clk);
    while (!wb_ack) begin
      if (waited == ACK_LIMIT) abort_on_timeout("wishbone ack");
      waited++;
      @(negedge clk);
    end
    check_equal("wb_ack_o delay", 8'(waited), 8'd1);  // one clock after the strobe.
    rdat = wb_rdat;  // registered with ack.
    @(posedge clk);
    wb_cyc <= 1'b0;
    wb_stb <= 1'b0;
    wb_we  <= 1'b0;
  endtask

  task automatic wb_write(reg_addr_e adr, logic [7:0] data);
    logic [7:0] unused_rdat;
    bus_cycle(1'b1, adr, data, unused_rdat);
  endtask

  task automatic wb_read(reg_addr_e adr, output logic [7:0] data);
    bus_cycle(1'b0, adr, 8'h00, data);
  endtask

  task automatic wait_status(logic [7:0] mask, logic [7:0] value, string what);
    logic [7:0] st;
    int         polls;
    polls = 0;
    wb_read(STATUS, st);
    while ((st & mask) != value) begin
      if (polls == POLL_LIMIT) abort_on_timeout(what);
      polls++;
      wb_read(STATUS, st);
    end
  endtask

  task automatic wait_irq(logic level, string what);
    int waited;
    waited = 0;
    @(negedge clk);
    while (irq !== level) begin
      if (waited == IRQ_LIMIT) abort_on_timeout(what);
      waited++;
      @(negedge clk);
    end
    checks++;
  endtask

  function automatic logic [7:0] ctrl_word(logic rx_en, logic tx_en, logic clr);
    reg_word_u w;
    w                  = '0;
    w.ctrl.rx_irq_en   = rx_en;
    w.ctrl.tx_irq_en   = tx_en;
    w.ctrl.clr_overrun = clr;
    return w;
  endfunction

  // waits for room in the tx queue, so the byte is never dropped
  task automatic send_byte(logic [7:0] b, logic expect_rx);
    wait_status(ST_TX_FULL, 8'h00, "tx queue space");
    wb_write(DATA, b);
    if (expect_rx) model_q.push_back(b);
  endtask

  task automatic receive_expected();
    logic [7:0] d;
    wait_status(ST_RX_EMPTY, 8'h00, "received byte");
    wb_read(DATA, d);
    check_equal("wb_dat_o (rx data)", d, model_q.pop_front());
  endtask

  task automatic reset_values();
    logic [7:0] d;
    @(negedge clk);
    check_equal("wb_ack_o after reset", {7'd0, wb_ack}, 8'h00);
    check_equal("txd_o after reset", {7'd0, txd}, 8'h01);
    check_equal("irq_o after reset", {7'd0, irq}, 8'h00);
    wb_read(STATUS, d);
    check_equal("status after reset", d, ST_TX_EMPTY | ST_RX_EMPTY);
    wb_read(DIV, d);
    check_equal("div after reset", d, 8'd15);
    wb_read(CTRL, d);
    check_equal("ctrl after reset", d, 8'h00);
  endtask

  task automatic register_readback();
    logic [31:0] r;
    logic [7:0]  d;
    logic [7:0]  got;
    repeat (8) begin
      r = $random(seed);
      d = r[7:0];
      if (d < 8'd3) d = d + 8'd3;  // bit time needs at least four clocks.
      wb_write(DIV, d);
      div_m = d;
      wb_write(CTRL, r[15:8]);
      ctrl_m = r[15:8] & 8'hdf;  // clr_overrun is not stored.
      wb_read(DIV, got);
      check_equal("div readback", got, div_m);
      wb_read(CTRL, got);
      check_equal("ctrl readback", got, ctrl_m);
    end
    wb_write(CTRL, 8'h00);
    ctrl_m = 8'h00;
  endtask

  task automatic loopback_order();
    logic [31:0] r;
    int          n;
    wb_write(DIV, 8'd6);
    repeat (3) begin
      r = $random(seed);
      n = 1 + int'(r[3:0]) % 12;  // stays below the rx queue depth.
      for (int i = 0; i < n; i++) begin
        r = $random(seed);
        send_byte(r[7:0], 1'b1);
      end
      while (model_q.size() > 0) receive_expected();
    end
  endtask

  task automatic tx_overflow();
    logic [31:0] r;
    reg_word_u   w;
    wb_write(DIV, 8'd200);
    // one byte leaves at once, sixteen wait, the last three are dropped
    for (int i = 0; i < 20; i++) begin
      r = $random(seed);
      wb_write(DATA, r[7:0]);
      if (i < 17) model_q.push_back(r[7:0]);
    end
    wb_read(STATUS, w);
    check_equal("status.tx_full", {7'd0, w.status.tx_full}, 8'h01);
    while (model_q.size() > 0) receive_expected();
    wait_status(ST_TX_BUSY | ST_TX_EMPTY, ST_TX_EMPTY, "transmitter idle");
    wb_read(STATUS, w);
    check_equal("status.rx_empty", {7'd0, w.status.rx_empty}, 8'h01);
  endtask

  task automatic rx_overrun();
    logic [31:0] r;
    reg_word_u   w;
    wb_write(DIV, 8'd6);
    for (int i = 0; i < 18; i++) begin
      r = $random(seed);
      send_byte(r[7:0], i < 16);
    end
    wait_status(ST_TX_BUSY | ST_TX_EMPTY, ST_TX_EMPTY, "transmitter idle");
    wb_read(STATUS, w);
    check_equal("status.rx_full", {7'd0, w.status.rx_full}, 8'h01);
    check_equal("status.rx_overrun", {7'd0, w.status.rx_overrun}, 8'h01);
    while (model_q.size() > 0) receive_expected();
    wb_write(CTRL, ctrl_word(1'b0, 1'b0, 1'b1));
    ctrl_m = 8'h00;
    wb_read(STATUS, w);
    check_equal("status.rx_overrun", {7'd0, w.status.rx_overrun}, 8'h00);
    check_equal("status.rx_empty", {7'd0, w.status.rx_empty}, 8'h01);
    wb_read(CTRL, w);
    check_equal("ctrl after clear", w, ctrl_m);
  endtask

  task automatic irq_behavior();
    logic [31:0] r;
    wb_write(CTRL, ctrl_word(1'b1, 1'b0, 1'b0));
    wait_irq(1'b0, "irq_o low with rx empty");
    r = $random(seed);
    send_byte(r[7:0], 1'b1);
    wait_irq(1'b1, "irq_o high on received byte");
    receive_expected();
    wait_irq(1'b0, "irq_o low after rx read");
    wb_write(CTRL, ctrl_word(1'b0, 1'b1, 1'b0));
    wait_irq(1'b1, "irq_o high with tx queue empty");
    wb_write(CTRL, 8'h00);
    wait_irq(1'b0, "irq_o low with interrupts off");
  endtask

  initial begin
    seed    = 33;
    errors  = 0;
    checks  = 0;
    clk     = 1'b0;
    rst_n   = 1'b0;
    wb_cyc  = 1'b0;
    wb_stb  = 1'b0;
    wb_we   = 1'b0;
    wb_adr  = '0;
    wb_wdat = '0;
    div_m   = 8'd15;
    ctrl_m  = 8'h00;
    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    reset_values();
    register_readback();
    loopback_order();
    tx_overflow();
    rx_overrun();
    irq_behavior();
    $display("checks: %0d errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== rtl/uart_top.sv ====
`default_nettype none
`include "uart_params.svh"

module uart_top (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [`UART_ADR_WIDTH-1:0]  wb_adr_i,
  input  logic [`UART_DATA_WIDTH-1:0] wb_dat_i,
  output logic [`UART_DATA_WIDTH-1:0] wb_dat_o,
  output logic                        wb_ack_o,
  output logic                        txd_o,
  input  logic                        rxd_i,
  output logic                        irq_o
);

  logic [`UART_DATA_WIDTH-1:0] divisor;
  logic                        tx_busy;

  fifo_if #(.WIDTH(`UART_DATA_WIDTH)) tx_q ();
  fifo_if #(.WIDTH(`UART_DATA_WIDTH)) rx_q ();

  fifo #(
    .DATA_WIDTH (`UART_DATA_WIDTH),
    .FIFO_DEPTH (`UART_FIFO_DEPTH)
  ) tx_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .q     (tx_q.store)
  );

  fifo #(
    .DATA_WIDTH (`UART_DATA_WIDTH),
    .FIFO_DEPTH (`UART_FIFO_DEPTH)
  ) rx_fifo (
    .clk   (clk),
    .rst_n (rst_n),
    .q     (rx_q.store)
  );

  uart_regs u_regs (
    .clk       (clk),
    .rst_n     (rst_n),
    .wb_cyc_i  (wb_cyc_i),
    .wb_stb_i  (wb_stb_i),
    .wb_we_i   (wb_we_i),
    .wb_adr_i  (wb_adr_i),
    .wb_dat_i  (wb_dat_i),
    .wb_dat_o  (wb_dat_o),
    .wb_ack_o  (wb_ack_o),
    .tx_q      (tx_q.producer),
    .rx_q      (rx_q.consumer),
    .tx_busy_i (tx_busy),
    .divisor_o (divisor),
    .irq_o     (irq_o)
  );

  uart_tx u_tx (
    .clk       (clk),
    .rst_n     (rst_n),
    .divisor_i (divisor),
    .q         (tx_q.consumer),
    .txd_o     (txd_o),
    .busy_o    (tx_busy)
  );

  uart_rx u_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .divisor_i (divisor),
    .rxd_i     (rxd_i),
    .q         (rx_q.producer)
  );

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
`default_nettype none
`include "uart_params.svh"

module uart_rx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`UART_DATA_WIDTH-1:0] divisor_i,
  input  logic                        rxd_i,
  fifo_if.producer                    q
);

  import uart_line_pkg::*;

  rx_state_e                   state;
  logic [1:0]                  sync;    // two-flop synchronizer.
  logic                        rx_prev;
  logic                        rx_s;
  logic [`UART_DATA_WIDTH-1:0] cnt;
  logic [2:0]                  bit_idx;
  logic [`UART_DATA_WIDTH-1:0] shreg;
  logic                        bit_end;
  logic                        sample;

  assign rx_s    = sync[1];
  assign bit_end = (cnt == '0);
  assign sample  = bit_end & (state == RX_DATA);

  // push only on a good stop bit; a full queue drops it inside the fifo
  assign q.wr_valid = (state == RX_STOP) & bit_end & rx_s;
  assign q.wdata    = shreg;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync    <= 2'b11;
      rx_prev <= 1'b1;
    end else begin
      sync    <= {sync[0], rxd_i};
      rx_prev <= rx_s;
    end
  end

  always_ff @(posedge clk) begin
    if (sample) begin
      shreg <= {rx_s, shreg[`UART_DATA_WIDTH-1:1]};  // lsb arrives first.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= RX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
    end else begin
      if (!bit_end) begin
        cnt <= cnt - 1'b1;
      end
      case (state)
        RX_IDLE: begin
          if (rx_prev & ~rx_s) begin
            cnt   <= divisor_i >> 1;  // half a bit to the start middle.
            state <= RX_START;
          end
        end
        RX_START: begin
          if (bit_end) begin
            if (!rx_s) begin
              cnt     <= divisor_i;
              bit_idx <= '0;
              state   <= RX_DATA;
            end else begin
              state <= RX_IDLE;  // glitch, not a start bit.
            end
          end
        end
        RX_DATA: begin
          if (bit_end) begin
            cnt <= divisor_i;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= RX_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`default_nettype none
`include "uart_params.svh"

module uart_tx (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [`UART_DATA_WIDTH-1:0] divisor_i,
  fifo_if.consumer                    q,
  output logic                        txd_o,
  output logic                        busy_o
);

  import uart_line_pkg::*;

  tx_state_e                   state;
  logic [`UART_DATA_WIDTH-1:0] cnt;     // clocks left in the current bit.
  logic [2:0]                  bit_idx;
  logic [`UART_DATA_WIDTH-1:0] shreg;
  logic                        bit_end;
  logic                        load;

  assign bit_end    = (cnt == '0);
  assign load       = (state == TX_IDLE) & ~q.empty;
  assign q.rd_valid = load;  // pop in the cycle the byte is taken.
  assign busy_o     = (state != TX_IDLE);

  always_ff @(posedge clk) begin
    if (load) begin
      shreg <= q.rdata;
    end else if (bit_end & (state == TX_START || state == TX_DATA)) begin
      shreg <= {1'b0, shreg[`UART_DATA_WIDTH-1:1]};  // lsb first.
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= TX_IDLE;
      cnt     <= '0;
      bit_idx <= '0;
      txd_o   <= 1'b1;  // line idles high.
    end else begin
      if (!bit_end) begin
        cnt <= cnt - 1'b1;
      end
      case (state)
        TX_IDLE: begin
          if (load) begin
            txd_o <= 1'b0;
            cnt   <= divisor_i;
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bit_end) begin
            txd_o   <= shreg[0];
            cnt     <= divisor_i;
            bit_idx <= '0;
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_end) begin
            cnt <= divisor_i;
            if (bit_idx == 3'd7) begin
              txd_o <= 1'b1;  // stop bit.
              state <= TX_STOP;
            end else begin
              txd_o   <= shreg[0];
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        default: begin
          if (bit_end) begin
            state <= TX_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== rtl/uart_regs.sv ====
`default_nettype none
`include "uart_params.svh"

module uart_regs (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  input  logic [`UART_ADR_WIDTH-1:0]  wb_adr_i,
  input  logic [`UART_DATA_WIDTH-1:0] wb_dat_i,
  output logic [`UART_DATA_WIDTH-1:0] wb_dat_o,
  output logic                        wb_ack_o,
  fifo_if.producer                    tx_q,
  fifo_if.consumer                    rx_q,
  input  logic                        tx_busy_i,
  output logic [`UART_DATA_WIDTH-1:0] divisor_o,
  output logic                        irq_o
);

  import uart_bus_pkg::*;

  reg_addr_e                 adr;
  logic                      access;
  logic                      wr_acc;
  logic                      rd_acc;
  reg_word_u                 wr_word;
  reg_word_u                 rd_word;
  reg_word_u                 status_word;
  ctrl_t                     ctrl_q;
  ctrl_t                     ctrl_wr;
  logic [`UART_DATA_WIDTH-1:0] div_q;
  logic                      overrun_q;
  logic                      clr_overrun;
  logic                      tx_low;

  assign adr    = reg_addr_e'(wb_adr_i);
  assign access = wb_cyc_i & wb_stb_i & ~wb_ack_o;  // one strobe per bus cycle.
  assign wr_acc = access & wb_we_i;
  assign rd_acc = access & ~wb_we_i;

  assign tx_q.wr_valid = wr_acc & (adr == DATA);
  assign tx_q.wdata    = wb_dat_i;
  assign rx_q.rd_valid = rd_acc & (adr == DATA);

  assign wr_word     = wb_dat_i;
  assign clr_overrun = wr_acc & (adr == CTRL) & wr_word.ctrl.clr_overrun;
  assign tx_low      = tx_q.empty | tx_q.almost_empty;  // tx queue at one entry or less.

  always_comb begin
    ctrl_wr             = wr_word.ctrl;
    ctrl_wr.clr_overrun = 1'b0;
  end

  always_comb begin
    status_word.status.rx_overrun      = overrun_q;
    status_word.status.tx_busy         = tx_busy_i;
    status_word.status.rx_almost_full  = rx_q.almost_full;
    status_word.status.tx_almost_empty = tx_q.almost_empty;
    status_word.status.rx_full         = rx_q.full;
    status_word.status.rx_empty        = rx_q.empty;
    status_word.status.tx_full         = tx_q.full;
    status_word.status.tx_empty        = tx_q.empty;
  end

  always_comb begin
    rd_word = '0;
    case (adr)
      DATA:    rd_word = rx_q.rdata;  // stale byte when rx is empty.
      STATUS:  rd_word = status_word;
      CTRL:    rd_word.ctrl = ctrl_q;
      default: rd_word = div_q;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_ack_o <= 1'b0;
    end else begin
      wb_ack_o <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (rd_acc) begin
      wb_dat_o <= rd_word;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q <= '0;
      div_q  <= `UART_DATA_WIDTH'(`UART_DIV_RESET);
    end else if (wr_acc) begin
      if (adr == CTRL) begin
        ctrl_q <= ctrl_wr;
      end
      if (adr == DIV) begin
        div_q <= wb_dat_i;
      end
    end
  end

  // a receiver push into a full queue loses the byte; set wins over clear
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overrun_q <= 1'b0;
    end else if (rx_q.wr_valid & rx_q.full) begin
      overrun_q <= 1'b1;
    end else if (clr_overrun) begin
      overrun_q <= 1'b0;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      irq_o <= 1'b0;
    end else begin
      irq_o <= (ctrl_q.rx_irq_en & ~rx_q.empty) | (ctrl_q.tx_irq_en & tx_low);
    end
  end

  assign divisor_o = div_q;

endmodule

`default_nettype wire

// ==== rtl/fifo.sv ====
`default_nettype none
`include "uart_params.svh"

module fifo #(
  parameter int DATA_WIDTH = `UART_DATA_WIDTH,
  parameter int FIFO_DEPTH = `UART_FIFO_DEPTH
) (
  input  logic   clk,
  input  logic   rst_n,
  fifo_if.store  q
);

  localparam int ADDR_WIDTH = $clog2(FIFO_DEPTH);

  logic [DATA_WIDTH-1:0] mem [0:FIFO_DEPTH-1];
  logic [ADDR_WIDTH:0]   wr_ptr;  // msb is the wrap bit.
  logic [ADDR_WIDTH:0]   rd_ptr;
  logic [ADDR_WIDTH-1:0] wr_idx;
  logic [ADDR_WIDTH-1:0] rd_idx;
  logic [ADDR_WIDTH-1:0] wr_idx_next;
  logic                  push;
  logic                  pop;

  assign wr_idx      = wr_ptr[ADDR_WIDTH-1:0];
  assign rd_idx      = rd_ptr[ADDR_WIDTH-1:0];
  assign wr_idx_next = wr_idx + 1'b1;

  assign push = q.wr_valid & ~q.full;   // writes into a full queue are dropped.
  assign pop  = q.rd_valid & ~q.empty;

  assign q.rdata = mem[rd_idx];

  assign q.empty        = (wr_ptr == rd_ptr);
  assign q.almost_empty = (rd_ptr + 1'b1 == wr_ptr);  // exactly one entry.
  assign q.full         = (wr_idx == rd_idx) & (wr_ptr[ADDR_WIDTH] ^ rd_ptr[ADDR_WIDTH]);
  assign q.almost_full  = (wr_idx_next == rd_idx);    // one slot left.

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_idx] <= q.wdata;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
    end else if (push) begin
      wr_ptr <= wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr <= '0;
    end else if (pop) begin
      rd_ptr <= rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/fifo_if.sv ====
`default_nettype none
`include "uart_params.svh"

interface fifo_if #(
  parameter int WIDTH = `UART_DATA_WIDTH
) ();

  logic             wr_valid;
  logic             rd_valid;
  logic [WIDTH-1:0] wdata;
  logic [WIDTH-1:0] rdata;  // oldest entry, valid while not empty.
  logic             empty;
  logic             almost_empty;
  logic             almost_full;
  logic             full;

  // both ends also see the flags of the far side so the register block can report them
  modport producer (output wr_valid, wdata,
                    input  full, almost_full, empty, almost_empty);

  modport consumer (output rd_valid,
                    input  rdata, empty, almost_empty, full, almost_full, wr_valid);

  modport store    (input  wr_valid, rd_valid, wdata,
                    output rdata, empty, almost_empty, almost_full, full);

endinterface

`default_nettype wire

// ==== rtl/uart_line_pkg.sv ====
`default_nettype none

package uart_line_pkg;

  typedef enum logic [1:0] {
    TX_IDLE  = 2'd0,
    TX_START = 2'd1,
    TX_DATA  = 2'd2,
    TX_STOP  = 2'd3
  } tx_state_e;

  typedef enum logic [1:0] {
    RX_IDLE  = 2'd0,
    RX_START = 2'd1,  // waiting for the start-bit middle.
    RX_DATA  = 2'd2,
    RX_STOP  = 2'd3
  } rx_state_e;

endpackage

`default_nettype wire

// ==== rtl/uart_bus_pkg.sv ====
`default_nettype none

package uart_bus_pkg;

  typedef enum logic [1:0] {
    DATA   = 2'd0,  // tx push on write, rx pop on read.
    STATUS = 2'd1,
    CTRL   = 2'd2,
    DIV    = 2'd3
  } reg_addr_e;

  typedef struct packed {
    logic rx_overrun;
    logic tx_busy;
    logic rx_almost_full;
    logic tx_almost_empty;
    logic rx_full;
    logic rx_empty;
    logic tx_full;
    logic tx_empty;
  } status_t;

  typedef struct packed {
    logic       rx_irq_en;
    logic       tx_irq_en;
    logic       clr_overrun;  // write-one strobe, never stored.
    logic [4:0] rsvd;
  } ctrl_t;

  // the bus byte seen as status on STATUS reads and as control on CTRL accesses
  typedef union packed {
    status_t status;
    ctrl_t   ctrl;
  } reg_word_u;

endpackage

`default_nettype wire

// ==== rtl/uart_params.svh ====
`ifndef UART_PARAMS_SVH
`define UART_PARAMS_SVH

`define UART_DATA_WIDTH 8   // one serial character.

`define UART_FIFO_DEPTH 16  // entries in each queue.

`define UART_DIV_RESET  15  // bit time of 16 clocks after reset.

`define UART_ADR_WIDTH  2   // four byte-wide registers.

`endif
